/* Makefile */
LOG = run.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		-f build.f --top-module tb_warpSe -Mdir obj_dir
	./obj_dir/Vtb_warpSe | tee $(LOG)
	grep -qx '=== PASS ===' $(LOG)

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ns \
		-f build.f --top-module tb_warpSe

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
+incdir+src
src/warpSePkg.sv
src/chipSelect.sv
src/fsbTerm.sv
src/ioSlave.sv
src/ioPostBuf.sv
src/ioMaster.sv
src/warpSe.sv
verif/warpSe_chk.sv
verif/tb_warpSe.sv

/* src/chipSelect.sv */
`timescale 1ns/1ns

module chipSelect (
	input  logic                 FCLK,
	input  logic                 rst,
	input  logic                 nAsFsb,
	input  warpSePkg::fsbAddr_u  aFsb,
	output logic                 bact,
	output warpSePkg::region_e   region
);

	// region of the address now on the bus.
	warpSePkg::region_e regionNext;

	// top nibble decode.
	// I/O space spans 0x8 through 0xE.
	always_comb begin
		case (aFsb.csView.region)
			4'h0, 4'h1, 4'h2, 4'h3: begin
				regionNext = warpSePkg::RAM;
			end
			4'h4: begin
				regionNext = warpSePkg::ROM;
			end
			4'h8, 4'h9, 4'hA, 4'hB, 4'hC, 4'hD, 4'hE: begin
				regionNext = warpSePkg::IO;
			end
			4'hF: begin
				regionNext = warpSePkg::IACK;
			end
			// holes in the map fall back to RAM.
			default: begin
				regionNext = warpSePkg::RAM;
			end
		endcase
	end

	// registered strobe gives the cycle-active level.
	// region is only updated while AS is low.
	always_ff @(posedge FCLK) begin
		if (rst) begin
			bact <= 1'b0;
			region <= warpSePkg::RAM;
		end else begin
			bact <= ~nAsFsb;
			if (!nAsFsb) begin
				region <= regionNext;
			end
		end
	end

endmodule

/* src/fsbTerm.sv */
`timescale 1ns/1ns
`include "warpSe_params.svh"

module fsbTerm (
	input  logic               FCLK,
	input  logic               rst,
	input  logic               bact,
	input  warpSePkg::region_e region,
	input  logic               ioReady,
	input  logic               ioBerr,
	output logic               nDtackFsb,
	output logic               nVpaFsb
);

	// bact one cycle late, for edge detect.
	logic       bactQ;
	// wait-state down-counter.
	logic [3:0] waitCnt;
	logic [3:0] waitLoad;
	// termination and vpa requests.
	logic       termQ;
	logic       vpaQ;
	logic       memCyc;

	assign memCyc = (region == warpSePkg::ROM) || (region == warpSePkg::RAM);

	// wait count for this region.
	always_comb begin
		if (region == warpSePkg::ROM) begin
			waitLoad = 4'(`WARPSE_ROM_WAIT);
		end else begin
			waitLoad = 4'(`WARPSE_RAM_WAIT);
		end
	end

	always_ff @(posedge FCLK) begin
		if (rst) begin
			bactQ <= 1'b0;
			waitCnt <= 4'd0;
			termQ <= 1'b0;
			vpaQ <= 1'b0;
		end else begin
			bactQ <= bact;
			// autovector on interrupt acknowledge.
			vpaQ <= bact && (region == warpSePkg::IACK);
			if (!bact) begin
				waitCnt <= 4'd0;
				termQ <= 1'b0;
			end else if (!bactQ) begin
				// rising edge of bact.
				// zero wait states end the cycle at once.
				waitCnt <= waitLoad;
				termQ <= memCyc && (waitLoad == 4'd0);
			end else if (memCyc) begin
				if (waitCnt != 4'd0) begin
					waitCnt <= waitCnt - 4'd1;
				end
				if (waitCnt == 4'd1) begin
					termQ <= 1'b1;
				end
			end else if (region == warpSePkg::IO) begin
				// I/O cycles end on the slave's ready.
				if (ioReady && !ioBerr) begin
					termQ <= 1'b1;
				end
			end
		end
	end

	// release with bact.
	// a bus error always wins over dtack.
	assign nDtackFsb = ~(bact & termQ & ~ioBerr);
	assign nVpaFsb = ~(bact & vpaQ);

endmodule

/* src/ioMaster.sv */
`timescale 1ns/1ns

module ioMaster (
	input  logic        FCLK,
	input  logic        rst,
	input  logic        empty,
	input  logic [22:0] headAddr,
	input  logic [15:0] headData,
	input  logic        headUds,
	input  logic        headLds,
	input  logic        headWe,
	output logic        pop,
	output logic [22:0] aIob,
	output logic [15:0] dIobOut,
	input  logic [15:0] dIobIn,
	output logic        nWeIob,
	output logic        nAsIob,
	output logic        nUdsIob,
	output logic        nLdsIob,
	input  logic        nDtackIob,
	input  logic        nBerrIob,
	output logic        done,
	output logic        berr,
	output logic [15:0] rdData
);

	localparam logic [1:0] MIdle    = 2'd0;
	localparam logic [1:0] MStrobe  = 2'd1;
	localparam logic [1:0] MWaitAck = 2'd2;
	localparam logic [1:0] MRelease = 2'd3;

	logic [1:0]        state;
	// bus error seen on this cycle.
	logic              errQ;
	logic              start;
	logic              ack;
	// entry on the IOB right now.
	warpSePkg::ioReq_t cur;

	assign start = (state == MIdle) && !empty;
	assign ack = !nDtackIob || !nBerrIob;

	always_ff @(posedge FCLK) begin
		if (rst) begin
			state <= MIdle;
			errQ <= 1'b0;
			pop <= 1'b0;
			done <= 1'b0;
			berr <= 1'b0;
			nWeIob <= 1'b1;
			nAsIob <= 1'b1;
			nUdsIob <= 1'b1;
			nLdsIob <= 1'b1;
		end else begin
			pop <= 1'b0;
			done <= 1'b0;
			berr <= 1'b0;
			case (state)
				MIdle: begin
					// address and direction set up a cycle ahead of AS.
					if (start) begin
						nWeIob <= ~headWe;
						state <= MStrobe;
					end
				end
				MStrobe: begin
					nAsIob <= 1'b0;
					nUdsIob <= ~cur.uds;
					nLdsIob <= ~cur.lds;
					state <= MWaitAck;
				end
				MWaitAck: begin
					// the entry is latched, so the buffer can let it go now.
					if (ack) begin
						errQ <= !nBerrIob;
						pop <= 1'b1;
						state <= MRelease;
					end
				end
				default: begin
					nAsIob <= 1'b1;
					nUdsIob <= 1'b1;
					nLdsIob <= 1'b1;
					nWeIob <= 1'b1;
					// only reads report back.
					done <= !cur.we && !errQ;
					berr <= !cur.we && errQ;
					state <= MIdle;
				end
			endcase
		end
	end

	// entry latch and read capture.
	always_ff @(posedge FCLK) begin
		if (start) begin
			cur <= '{addr: headAddr, data: headData, uds: headUds,
				lds: headLds, we: headWe};
		end
		if ((state == MWaitAck) && !nDtackIob && !cur.we) begin
			rdData <= dIobIn;
		end
	end

	assign aIob = cur.addr;
	assign dIobOut = cur.data;

endmodule

/* src/ioPostBuf.sv */
`timescale 1ns/1ns
`include "warpSe_params.svh"

module ioPostBuf (
	input  logic        FCLK,
	input  logic        rst,
	input  logic        push,
	input  logic [22:0] pushAddr,
	input  logic [15:0] pushData,
	input  logic        pushUds,
	input  logic        pushLds,
	input  logic        pushWe,
	input  logic        pop,
	output logic        full,
	output logic        empty,
	output logic [22:0] headAddr,
	output logic [15:0] headData,
	output logic        headUds,
	output logic        headLds,
	output logic        headWe
);

	localparam int Depth = `WARPSE_IOB_DEPTH;
	localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;

	warpSePkg::ioReq_t mem [Depth];
	logic [PtrW-1:0]   wrPtr;
	logic [PtrW-1:0]   rdPtr;
	logic [PtrW:0]     count;
	logic              doPush;
	logic              doPop;

	// pointer step with wrap, for any depth.
	function automatic logic [PtrW-1:0] ptrNext(input logic [PtrW-1:0] ptr);
		if (ptr == PtrW'(Depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = (count == (PtrW + 1)'(Depth));
	assign empty = (count == '0);
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	always_ff @(posedge FCLK) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= ptrNext(wrPtr);
			end
			if (doPop) begin
				rdPtr <= ptrNext(rdPtr);
			end
			// simultaneous push and pop leaves count alone.
			if (doPush && !doPop) begin
				count <= count + 1'b1;
			end else if (doPop && !doPush) begin
				count <= count - 1'b1;
			end
		end
	end

	// storage.
	always_ff @(posedge FCLK) begin
		if (doPush) begin
			mem[wrPtr] <= '{addr: pushAddr, data: pushData, uds: pushUds,
				lds: pushLds, we: pushWe};
		end
	end

	// oldest entry.
	assign headAddr = mem[rdPtr].addr;
	assign headData = mem[rdPtr].data;
	assign headUds = mem[rdPtr].uds;
	assign headLds = mem[rdPtr].lds;
	assign headWe = mem[rdPtr].we;

endmodule

/* src/ioSlave.sv */
`timescale 1ns/1ns

module ioSlave (
	input  logic                FCLK,
	input  logic                rst,
	input  logic                bact,
	input  warpSePkg::region_e  region,
	input  warpSePkg::fsbAddr_u aFsb,
	input  logic [15:0]         dFsbIn,
	input  logic                nUdsFsb,
	input  logic                nLdsFsb,
	input  logic                nWeFsb,
	input  logic                full,
	output logic                push,
	output logic [22:0]         pushAddr,
	output logic [15:0]         pushData,
	output logic                pushUds,
	output logic                pushLds,
	output logic                pushWe,
	input  logic                done,
	input  logic                berr,
	input  logic [15:0]         rdData,
	output logic [15:0]         dFsbOut,
	output logic                ioReady,
	output logic                nBerrFsb
);

	localparam logic [1:0] SIdle   = 2'd0;
	localparam logic [1:0] SPush   = 2'd1;
	localparam logic [1:0] SWaitRd = 2'd2;
	localparam logic [1:0] SHold   = 2'd3;

	logic [1:0]        state;
	logic              berrQ;
	logic              ioCyc;
	logic              accept;
	// request being pushed.
	warpSePkg::ioReq_t req;

	assign ioCyc = bact && (region == warpSePkg::IO);
	// one request per I/O cycle, only with room in the buffer.
	assign accept = (state == SIdle) && ioCyc && !full;

	always_ff @(posedge FCLK) begin
		if (rst) begin
			state <= SIdle;
			push <= 1'b0;
			ioReady <= 1'b0;
			berrQ <= 1'b0;
		end else begin
			push <= accept;
			case (state)
				SIdle: begin
					if (accept) begin
						state <= SPush;
					end
				end
				SPush: begin
					// posted write.
					// ready as soon as it is queued.
					if (req.we) begin
						ioReady <= 1'b1;
						state <= SHold;
					end else begin
						state <= SWaitRd;
					end
				end
				SWaitRd: begin
					if (done) begin
						ioReady <= 1'b1;
						state <= SHold;
					end else if (berr) begin
						berrQ <= 1'b1;
						state <= SHold;
					end
				end
				default: begin
					// hold until the CPU drops AS.
					if (!bact) begin
						ioReady <= 1'b0;
						berrQ <= 1'b0;
						state <= SIdle;
					end
				end
			endcase
		end
	end

	// request and read data capture.
	always_ff @(posedge FCLK) begin
		if (accept) begin
			req.addr <= {aFsb.iobView.dev, aFsb.iobView.regOfs};
			req.data <= dFsbIn;
			req.uds <= ~nUdsFsb;
			req.lds <= ~nLdsFsb;
			req.we <= ~nWeFsb;
		end
		if ((state == SWaitRd) && done) begin
			dFsbOut <= rdData;
		end
	end

	assign pushAddr = req.addr;
	assign pushData = req.data;
	assign pushUds = req.uds;
	assign pushLds = req.lds;
	assign pushWe = req.we;
	// error held for the rest of the bus cycle.
	assign nBerrFsb = ~(berrQ & bact);

endmodule

/* src/warpSe.sv */
`timescale 1ns/1ns

module warpSe (
	input  logic                FCLK,
	input  logic                rst,
	input  warpSePkg::fsbAddr_u aFsb,
	input  logic [15:0]         dFsbIn,
	output logic [15:0]         dFsbOut,
	input  logic                nAsFsb,
	input  logic                nUdsFsb,
	input  logic                nLdsFsb,
	input  logic                nWeFsb,
	output logic                nDtackFsb,
	output logic                nVpaFsb,
	output logic                nBerrFsb,
	output logic [22:0]         aIob,
	output logic [15:0]         dIobOut,
	input  logic [15:0]         dIobIn,
	output logic                nWeIob,
	output logic                nAsIob,
	output logic                nUdsIob,
	output logic                nLdsIob,
	input  logic                nDtackIob,
	input  logic                nBerrIob
);

	// cycle detect and decode.
	logic               bact;
	warpSePkg::region_e region;
	// slave to termination.
	logic               ioReady;
	logic               ioBerr;
	// slave to buffer.
	logic               push;
	logic [22:0]        pushAddr;
	logic [15:0]        pushData;
	logic               pushUds;
	logic               pushLds;
	logic               pushWe;
	logic               full;
	// buffer to master.
	logic               empty;
	logic               pop;
	logic [22:0]        headAddr;
	logic [15:0]        headData;
	logic               headUds;
	logic               headLds;
	logic               headWe;
	// master back to slave.
	logic               done;
	logic               berr;
	logic [15:0]        rdData;

	// level form of the FSB bus error.
	assign ioBerr = ~nBerrFsb;

	chipSelect u_chipSelect (
		.FCLK(FCLK), .rst(rst), .nAsFsb(nAsFsb), .aFsb(aFsb),
		.bact(bact), .region(region)
	);

	fsbTerm u_fsbTerm (
		.FCLK(FCLK), .rst(rst), .bact(bact), .region(region),
		.ioReady(ioReady), .ioBerr(ioBerr),
		.nDtackFsb(nDtackFsb), .nVpaFsb(nVpaFsb)
	);

	ioSlave u_ioSlave (
		.FCLK(FCLK), .rst(rst), .bact(bact), .region(region), .aFsb(aFsb),
		.dFsbIn(dFsbIn), .nUdsFsb(nUdsFsb), .nLdsFsb(nLdsFsb), .nWeFsb(nWeFsb),
		.full(full), .push(push), .pushAddr(pushAddr), .pushData(pushData),
		.pushUds(pushUds), .pushLds(pushLds), .pushWe(pushWe),
		.done(done), .berr(berr), .rdData(rdData), .dFsbOut(dFsbOut),
		.ioReady(ioReady), .nBerrFsb(nBerrFsb)
	);

	ioPostBuf u_ioPostBuf (
		.FCLK(FCLK), .rst(rst), .push(push), .pushAddr(pushAddr),
		.pushData(pushData), .pushUds(pushUds), .pushLds(pushLds),
		.pushWe(pushWe), .pop(pop), .full(full), .empty(empty),
		.headAddr(headAddr), .headData(headData), .headUds(headUds),
		.headLds(headLds), .headWe(headWe)
	);

	ioMaster u_ioMaster (
		.FCLK(FCLK), .rst(rst), .empty(empty), .headAddr(headAddr),
		.headData(headData), .headUds(headUds), .headLds(headLds),
		.headWe(headWe), .pop(pop), .aIob(aIob), .dIobOut(dIobOut),
		.dIobIn(dIobIn), .nWeIob(nWeIob), .nAsIob(nAsIob), .nUdsIob(nUdsIob),
		.nLdsIob(nLdsIob), .nDtackIob(nDtackIob), .nBerrIob(nBerrIob),
		.done(done), .berr(berr), .rdData(rdData)
	);

endmodule

/* src/warpSePkg.sv */
package warpSePkg;

	// FSB address A[23:1], seen two ways.
	typedef union packed {
		// chip-select view.
		struct packed {
			logic [3:0]  region;
			logic [11:0] page;
			logic [6:0]  offs;
		} csView;
		// I/O bus view, device number and register offset.
		struct packed {
			logic [2:0]  dev;
			logic [19:0] regOfs;
		} iobView;
	} fsbAddr_u;

	// decoded FSB region.
	typedef enum logic [1:0] {RAM, ROM, IO, IACK} region_e;

	// one queued I/O request.
	// strobes and we are active high here.
	typedef struct packed {
		logic [22:0] addr;
		logic [15:0] data;
		logic        uds;
		logic        lds;
		logic        we;
	} ioReq_t;

endpackage

/* src/warpSe_params.svh */
`ifndef WARPSE_PARAMS_SVH
`define WARPSE_PARAMS_SVH

// wait states for a ROM cycle.
// counted from the first FCLK edge that sees bact.
`define WARPSE_ROM_WAIT 2

// wait states for a RAM cycle.
`define WARPSE_RAM_WAIT 1

// entries in the posted I/O request buffer.
// any depth of 1 or more works, 2 and 4 are typical.
`define WARPSE_IOB_DEPTH 2

`endif

/* verif/tb_warpSe.sv */
`timescale 1ns/1ns
`include "warpSe_params.svh"

module tb_warpSe;

	// run length sets the watchdog limit.
	localparam int NumWr = 8;
	localparam int NumPost = 4;
	localparam int NumFsbCycles = 5 + 2 * NumWr + NumPost + 1;
	localparam int CycleLimit = 40 * NumFsbCycles + 200;

	logic                FCLK;
	logic                rst;
	warpSePkg::fsbAddr_u aFsb;
	logic [15:0]         dFsbIn;
	logic [15:0]         dFsbOut;
	logic                nAsFsb;
	logic                nUdsFsb;
	logic                nLdsFsb;
	logic                nWeFsb;
	logic                nDtackFsb;
	logic                nVpaFsb;
	logic                nBerrFsb;
	logic [22:0]         aIob;
	logic [15:0]         dIobOut;
	logic [15:0]         dIobIn = 16'h0000;
	logic                nWeIob;
	logic                nAsIob;
	logic                nUdsIob;
	logic                nLdsIob;
	logic                nDtackIob = 1'b1;
	logic                nBerrIob = 1'b1;

	// stimulus LFSR.
	logic [31:0] stimSeed;
	// device model state with its own LFSR.
	logic [31:0] devSeed = 32'hf366;
	logic [15:0] devMem [logic [22:0]];
	logic        devArmed = 1'b0;
	logic [2:0]  devWait;
	logic [1:0]  devDly;
	logic [15:0] devWord;
	// IOB write log in bus order.
	logic [22:0] logAddr [$];
	logic [15:0] logData [$];
	// issued FSB writes in CPU order.
	logic [22:0] wrAddrQ [$];
	logic [15:0] wrDataQ [$];
	// expected memory as the CPU sees it.
	logic [15:0] shadow [logic [22:0]];
	// reads waiting for the compare process.
	logic [15:0] gotQ [$];
	logic [15:0] expQ [$];
	logic [15:0] cmpGot;
	logic [15:0] cmpExp;
	int          cycleCnt = 0;
	int          wrIssued = 0;

	warpSe u_warpSe (
		.FCLK(FCLK), .rst(rst), .aFsb(aFsb), .dFsbIn(dFsbIn), .dFsbOut(dFsbOut),
		.nAsFsb(nAsFsb), .nUdsFsb(nUdsFsb), .nLdsFsb(nLdsFsb), .nWeFsb(nWeFsb),
		.nDtackFsb(nDtackFsb), .nVpaFsb(nVpaFsb), .nBerrFsb(nBerrFsb),
		.aIob(aIob), .dIobOut(dIobOut), .dIobIn(dIobIn), .nWeIob(nWeIob),
		.nAsIob(nAsIob), .nUdsIob(nUdsIob), .nLdsIob(nLdsIob),
		.nDtackIob(nDtackIob), .nBerrIob(nBerrIob)
	);

	bind ioMaster warpSeChk u_ioChk (
		.FCLK(FCLK), .rst(rst), .strobeN(nAsIob), .ackN(nDtackIob & nBerrIob),
		.termN(1'b1), .berrN(1'b1),
		.outsIdle(nAsIob & nUdsIob & nLdsIob & ~pop & ~done & ~berr)
	);

	bind fsbTerm warpSeChk u_termChk (
		.FCLK(FCLK), .rst(rst), .strobeN(1'b1), .ackN(1'b1),
		.termN(~(bact & termQ)), .berrN(~ioBerr), .outsIdle(nDtackFsb & nVpaFsb)
	);

	initial begin
		FCLK = 1'b0;
	end

	always #5 FCLK = ~FCLK;

	// Galois step for x^32+x^22+x^2+x+1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h80200003;
		end
		return n;
	endfunction

	// fill word for unwritten device words.
	// every address bit takes part.
	function automatic logic [15:0] fillWord(input logic [22:0] a);
		return a[15:0] ^ {a[22:16], 9'h0a5};
	endfunction

	function automatic logic [15:0] mergeBytes(input logic [15:0] old,
		input logic [15:0] nw, input logic uds, input logic lds);
		logic [15:0] w;
		w = old;
		if (uds) begin
			w[15:8] = nw[15:8];
		end
		if (lds) begin
			w[7:0] = nw[7:0];
		end
		return w;
	endfunction

	// reference model.
	// merged bytes of all earlier writes to this word.
	function automatic logic [15:0] expRead(input logic [22:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return fillWord(a);
	endfunction

	// region implied by the terminator and its latency.
	function automatic warpSePkg::region_e termRegion(input logic [2:0] term,
		input int lat);
		if (term[1]) begin
			return warpSePkg::IACK;
		end
		if (term[0]) begin
			return warpSePkg::IO;
		end
		if (lat == `WARPSE_RAM_WAIT + 2) begin
			return warpSePkg::RAM;
		end
		if (lat == `WARPSE_ROM_WAIT + 2) begin
			return warpSePkg::ROM;
		end
		return warpSePkg::IO;
	endfunction

	task automatic stopRun();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic checkData(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkAddr(input string name, input logic [22:0] got,
		input logic [22:0] exp);
		if (got !== exp) begin
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkRegion(input string name, input warpSePkg::region_e got,
		input warpSePkg::region_e exp);
		if (got !== exp) begin
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkTerm(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkLevel(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], stimSeed[0]};
			stimSeed = lfsrNext(stimSeed);
		end
	endtask

	// dev 4 to 6 only.
	// dev 7 is the error device.
	task automatic randIoAddr(output logic [22:0] a);
		logic [31:0] r;
		logic [2:0]  dev;
		takeBits(22, r);
		dev = {1'b1, r[21:20]};
		if (dev == 3'b111) begin
			dev = 3'b110;
		end
		a = {dev, r[19:0]};
	endtask

	task automatic randMemAddr(input logic [3:0] nib, output logic [22:0] a);
		logic [31:0] r;
		takeBits(19, r);
		a = {nib, r[18:0]};
	endtask

	// one FSB cycle.
	// called right after a clock edge.
	// term holds {dtack, vpa, berr} active high.
	task automatic busCycle(input logic [22:0] a, input logic we, input logic uds,
		input logic lds, input logic [15:0] d, output logic [15:0] rd,
		output logic [2:0] term, output int lat, output int logSeen);
		int n;
		n = 0;
		aFsb <= a;
		dFsbIn <= d;
		nWeFsb <= ~we;
		nUdsFsb <= ~uds;
		nLdsFsb <= ~lds;
		nAsFsb <= 1'b0;
		do begin
			@(posedge FCLK);
			n++;
		end while (nDtackFsb && nVpaFsb && nBerrFsb);
		term = {~nDtackFsb, ~nVpaFsb, ~nBerrFsb};
		rd = dFsbOut;
		lat = n - 1;
		logSeen = logAddr.size();
		if ($countones(term) > 1) begin
			$display("more than one FSB terminator low at address 0x%h", a);
			stopRun();
		end
		nAsFsb <= 1'b1;
		nUdsFsb <= 1'b1;
		nLdsFsb <= 1'b1;
		nWeFsb <= 1'b1;
		repeat (2) @(posedge FCLK);
	endtask

	task automatic ioWrite(input logic [22:0] a, input logic uds, input logic lds,
		input logic [15:0] d);
		logic [15:0] rd;
		logic [2:0]  term;
		int          lat;
		int          logSeen;
		shadow[a] = mergeBytes(expRead(a), d, uds, lds);
		wrAddrQ.push_back(a);
		wrDataQ.push_back(d);
		wrIssued++;
		busCycle(a, 1'b1, uds, lds, d, rd, term, lat, logSeen);
		checkLevel("nDtackFsb", ~term[2], 1'b0);
		// a posted write ends before its own IOB cycle.
		if (logSeen >= wrIssued) begin
			$display("write to 0x%h finished on the IOB before its FSB cycle ended", a);
			stopRun();
		end
	endtask

	task automatic ioRead(input logic [22:0] a);
		logic [15:0] rd;
		logic [2:0]  term;
		int          lat;
		int          logSeen;
		busCycle(a, 1'b0, 1'b1, 1'b1, 16'h0000, rd, term, lat, logSeen);
		checkRegion("region", termRegion(term, lat), warpSePkg::IO);
		gotQ.push_back(rd);
		expQ.push_back(expRead(a));
	endtask

	// IOB device answers in 1 to 4 cycles.
	always @(posedge FCLK) begin
		if (rst || nAsIob) begin
			nDtackIob <= 1'b1;
			nBerrIob <= 1'b1;
			devArmed <= 1'b0;
		end else if (nDtackIob && nBerrIob) begin
			if (!devArmed) begin
				devDly[1] = devSeed[0];
				devSeed = lfsrNext(devSeed);
				devDly[0] = devSeed[0];
				devSeed = lfsrNext(devSeed);
				devWait <= {1'b0, devDly} + 3'd1;
				devArmed <= 1'b1;
			end else if (devWait != 3'd1) begin
				devWait <= devWait - 3'd1;
			end else if (aIob[22:20] == 3'd7) begin
				nBerrIob <= 1'b0;
			end else begin
				devWord = devMem.exists(aIob) ? devMem[aIob] : fillWord(aIob);
				if (!nWeIob) begin
					devMem[aIob] = mergeBytes(devWord, dIobOut, ~nUdsIob, ~nLdsIob);
					logAddr.push_back(aIob);
					logData.push_back(dIobOut);
				end else begin
					dIobIn <= devWord;
				end
				nDtackIob <= 1'b0;
			end
		end
	end

	// read results against the reference.
	always @(posedge FCLK) begin
		if (gotQ.size() != 0) begin
			cmpGot = gotQ.pop_front();
			cmpExp = expQ.pop_front();
			checkData("dFsbOut", cmpGot, cmpExp);
		end
	end

	always @(posedge FCLK) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= CycleLimit) begin
			$display("timeout, the bus cycles did not finish in time");
			stopRun();
		end
	end

	initial begin
		logic [22:0] a;
		logic [22:0] wrAddr [NumWr];
		logic [31:0] r;
		logic [1:0]  lanes;
		logic [15:0] rd;
		logic [2:0]  term;
		int          lat;
		int          logSeen;
		stimSeed = 32'hf366;
		rst = 1'b1;
		aFsb = '0;
		dFsbIn = 16'h0000;
		nAsFsb = 1'b1;
		nUdsFsb = 1'b1;
		nLdsFsb = 1'b1;
		nWeFsb = 1'b1;
		repeat (3) @(posedge FCLK);
		rst <= 1'b0;
		@(posedge FCLK);

		// idle levels out of reset.
		checkLevel("nDtackFsb", nDtackFsb, 1'b1);
		checkLevel("nVpaFsb", nVpaFsb, 1'b1);
		checkLevel("nBerrFsb", nBerrFsb, 1'b1);
		checkLevel("nAsIob", nAsIob, 1'b1);
		checkLevel("nUdsIob", nUdsIob, 1'b1);
		checkLevel("nLdsIob", nLdsIob, 1'b1);

		// fixed wait states for ROM and RAM.
		for (int i = 0; i < 2; i++) begin
			randMemAddr(4'h4, a);
			busCycle(a, 1'b0, 1'b1, 1'b1, 16'h0000, rd, term, lat, logSeen);
			checkRegion("region", termRegion(term, lat), warpSePkg::ROM);
			checkTerm("nDtackFsb latency", lat, `WARPSE_ROM_WAIT + 2);
			randMemAddr({2'b00, a[1:0]}, a);
			busCycle(a, 1'b1, 1'b1, 1'b0, 16'h1234, rd, term, lat, logSeen);
			checkRegion("region", termRegion(term, lat), warpSePkg::RAM);
			checkTerm("nDtackFsb latency", lat, `WARPSE_RAM_WAIT + 2);
		end

		// autovectored interrupt acknowledge.
		randMemAddr(4'hF, a);
		busCycle(a, 1'b0, 1'b1, 1'b1, 16'h0000, rd, term, lat, logSeen);
		checkLevel("nVpaFsb", ~term[1], 1'b0);
		checkLevel("nDtackFsb", ~term[2], 1'b1);
		checkRegion("region", termRegion(term, lat), warpSePkg::IACK);
		checkTerm("nVpaFsb latency", lat, 2);

		// random writes.
		// odd ones hit the word before with other lanes.
		for (int i = 0; i < NumWr; i++) begin
			if (i % 2 == 1) begin
				wrAddr[i] = wrAddr[i - 1];
			end else begin
				randIoAddr(wrAddr[i]);
			end
			takeBits(2, r);
			lanes = r[1:0];
			if (lanes == 2'b00) begin
				lanes = 2'b11;
			end
			takeBits(16, r);
			ioWrite(wrAddr[i], lanes[1], lanes[0], r[15:0]);
		end
		for (int i = 0; i < NumWr; i++) begin
			ioRead(wrAddr[i]);
		end

		// back-to-back posted writes.
		for (int i = 0; i < NumPost; i++) begin
			randIoAddr(a);
			takeBits(16, r);
			ioWrite(a, 1'b1, 1'b1, r[15:0]);
		end
		while (logAddr.size() < wrIssued) begin
			@(posedge FCLK);
		end
		for (int i = 0; i < wrIssued; i++) begin
			checkAddr("aIob", logAddr[i], wrAddrQ[i]);
			checkData("dIobOut", logData[i], wrDataQ[i]);
		end

		// dev 7 answers with a bus error.
		// A[20] held low so the cycle stays out of IACK space.
		takeBits(19, r);
		a = {3'b111, 1'b0, r[18:0]};
		busCycle(a, 1'b0, 1'b1, 1'b1, 16'h0000, rd, term, lat, logSeen);
		checkLevel("nBerrFsb", ~term[0], 1'b0);
		checkLevel("nDtackFsb", ~term[2], 1'b1);
		checkRegion("region", termRegion(term, lat), warpSePkg::IO);

		while (gotQ.size() != 0) begin
			@(posedge FCLK);
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* verif/warpSe_chk.sv */
`timescale 1ns/1ns

module warpSeChk (
	input logic FCLK,
	input logic rst,
	input logic strobeN,
	input logic ackN,
	input logic termN,
	input logic berrN,
	input logic outsIdle
);

	// IOB address strobe held until the device answers.
	aStrobeHold: assert property (@(posedge FCLK) disable iff (rst)
		(!strobeN && ackN) |=> !strobeN)
		else $error("IOB strobe released before dtack or berr");

	// dtack and bus error are exclusive.
	aOneTerm: assert property (@(posedge FCLK) disable iff (rst)
		!(!termN && !berrN))
		else $error("dtack and bus error low together");

	// quiet outputs once reset has taken hold.
	aResetQuiet: assert property (@(posedge FCLK)
		(rst && $past(rst)) |-> outsIdle)
		else $error("output active during reset");

endmodule
